// File: verilog/aether_params.svh
`ifndef AETHER_PARAMS_SVH
`define AETHER_PARAMS_SVH

// --------------------
// Datapath widths
// --------------------
`define AE_WORD_W     16         // Command param and buffer word
`define AE_ADDR_W     8          // Buffer address
`define AE_LEN_W      9          // Holds 1..256
`define AE_ACC_W      24         // MAC accumulator, no overflow at 256 terms

// Input buffer size
`define AE_BUF_DEPTH  256

// --------------------
// Register reset values
// --------------------
`define AE_VERSION    16'h6C00
`define AE_HW_ID      16'hB2E9
`define AE_LEN_RESET  9'd4       // Default vector length

`endif

// File: verilog/aether_pkg.sv
`include "aether_params.svh"

package aether_pkg;

  // Vector types
  typedef logic [`AE_WORD_W-1:0] word_t;            // Buffer or data word
  typedef logic [`AE_ADDR_W-1:0] addr_t;            // Buffer address
  typedef logic [`AE_LEN_W-1:0] len_t;              // Vector length
  typedef logic signed [7:0] operand_t;             // One byte of a word
  typedef logic signed [`AE_ACC_W-1:0] acc_t;       // Accumulator value

  // Host instruction codes, unknown codes act as NOP
  typedef enum logic [3:0] {
    NOP        = 4'd0,
    READ_REG   = 4'd1,
    WRITE_REG  = 4'd2,
    LOAD_START = 4'd3,
    LOAD_CONT  = 4'd4,
    RUN_DENSE  = 4'd5,
    CLEAR      = 4'd6
  } instr_e;

  // Register map, param_1 selects
  typedef enum logic [3:0] {
    VERSN  = 4'd0,
    HWRID  = 4'd1,
    LENGTH = 4'd2,
    STATS  = 4'd3,
    RESULT = 4'd4
  } reg_addr_e;

  typedef enum logic [1:0] {IDLE, FETCH, DRAIN, FINISH} dense_state_e;

endpackage

// File: verilog/aether_buf_if.sv
`timescale 1ns/10ps
`include "aether_params.svh"

interface aether_buf_if;

  // Write side, driven by the host load path
  logic                  wr_en;
  logic [`AE_ADDR_W-1:0] wr_addr;
  logic [`AE_WORD_W-1:0] wr_data;

  // Read side, one cycle latency
  logic [`AE_ADDR_W-1:0] rd_addr;
  logic [`AE_WORD_W-1:0] rd_data;

  modport loader    (output wr_en, output wr_addr, output wr_data);
  modport sequencer (output rd_addr);
  modport mac       (input rd_data);
  modport mem       (input wr_en, input wr_addr, input wr_data,
                     input rd_addr, output rd_data);

endinterface

// File: verilog/aether_addr_counter.sv
`timescale 1ns/10ps

// Saturating up counter, used as load and read pointer
module aether_addr_counter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              clr_i,      // Back to zero, beats enable
  input  logic              en_i,       // Step by one
  input  aether_pkg::addr_t last_i,     // Stop value
  output aether_pkg::addr_t count_o,
  output logic              at_end_o
);

  aether_pkg::addr_t count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      count_q <= '0;
    end else if (en_i && !at_end_o) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o  = count_q;
  assign at_end_o = (count_q == last_i);  // Hold point

  // Pointer stays in range while stepping, relies on last_i being stable
  a_count_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    (en_i && !clr_i) |-> (count_q <= last_i))
    else $error("addr counter past last value");

endmodule

// File: verilog/aether_input_buffer.sv
`timescale 1ns/10ps
`include "aether_params.svh"

// On-chip input buffer
// One write port from the loader, one registered read port
module aether_input_buffer (
  input logic       clk_i,
  aether_buf_if.mem buf_i
);

  aether_pkg::word_t mem_q [`AE_BUF_DEPTH];   // Payload storage, no reset

  // --------------------
  // Write port
  // --------------------
  always_ff @(posedge clk_i) begin
    if (buf_i.wr_en) begin
      mem_q[buf_i.wr_addr] <= buf_i.wr_data;
    end
  end

  // --------------------
  // Read port
  // --------------------
  // Word shows up the cycle after the address
  always_ff @(posedge clk_i) begin
    buf_i.rd_data <= mem_q[buf_i.rd_addr];
  end

  // Loader must keep its pointer known and inside the array
  a_wr_addr_ok: assert property (@(posedge clk_i)
    buf_i.wr_en |-> (!$isunknown(buf_i.wr_addr) && int'(buf_i.wr_addr) < `AE_BUF_DEPTH))
    else $error("buffer write out of range");

endmodule

// File: verilog/aether_mac.sv
`timescale 1ns/10ps
`include "aether_params.svh"

// Signed byte x byte multiply-accumulate on one buffer word
module aether_mac (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              clr_i,       // Zero the sum
  input  logic              en_i,        // Add this word's product
  aether_buf_if.mac         buf_i,
  output aether_pkg::word_t result_o     // Saturated sum
);

  // Signed 16-bit limits in accumulator width
  localparam aether_pkg::acc_t sat_max = aether_pkg::acc_t'((1 << (`AE_WORD_W - 1)) - 1);
  localparam aether_pkg::acc_t sat_min = -sat_max - 1;

  aether_pkg::operand_t op_lo;
  aether_pkg::operand_t op_hi;
  logic signed [15:0]   product;
  aether_pkg::acc_t     acc_q;

  // Split the word, low byte times high byte
  assign op_lo   = buf_i.rd_data[7:0];
  assign op_hi   = buf_i.rd_data[15:8];
  assign product = op_lo * op_hi;         // Both signed, full 16-bit result

  // --------------------
  // Accumulator
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= acc_q + aether_pkg::acc_t'(product);   // Sign-extended add
    end
  end

  // Clamp to the readback width
  always_comb begin
    if (acc_q > sat_max) begin
      result_o = sat_max[`AE_WORD_W-1:0];
    end else if (acc_q < sat_min) begin
      result_o = sat_min[`AE_WORD_W-1:0];
    end else begin
      result_o = acc_q[`AE_WORD_W-1:0];   // In range, plain truncate
    end
  end

endmodule

// File: verilog/aether_dense_ctrl.sv
`timescale 1ns/10ps
`include "aether_params.svh"

// Dense run sequencer
// Walks the buffer from address 0 for length_i words and steers the MAC
module aether_dense_ctrl (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             start_i,     // One-cycle run request
  input  aether_pkg::len_t length_i,    // Held stable by decoder while busy
  aether_buf_if.sequencer  buf_o,
  output logic             mac_clr_o,
  output logic             mac_en_o,
  output logic             busy_o,
  output logic             done_o       // One-cycle, in FINISH
);

  aether_pkg::dense_state_e state_q;
  aether_pkg::dense_state_e state_nxt;

  aether_pkg::addr_t rd_count;
  aether_pkg::addr_t rd_last;
  logic              rd_at_end;
  logic              fetch;             // Read strobe
  logic              mac_en_q;

  assign fetch   = (state_q == aether_pkg::FETCH);
  assign rd_last = aether_pkg::addr_t'(length_i - 1'b1);   // 256 maps to 255

  // Read pointer, cleared together with the MAC
  aether_addr_counter u_rd_ptr (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clr_i    (mac_clr_o),
    .en_i     (fetch),
    .last_i   (rd_last),
    .count_o  (rd_count),
    .at_end_o (rd_at_end)
  );

  assign buf_o.rd_addr = rd_count;

  // --------------------
  // State machine
  // --------------------
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      aether_pkg::IDLE:   if (start_i) state_nxt = aether_pkg::FETCH;
      aether_pkg::FETCH:  if (rd_at_end) state_nxt = aether_pkg::DRAIN;  // Last read issued
      aether_pkg::DRAIN:  state_nxt = aether_pkg::FINISH;   // Last word into MAC
      aether_pkg::FINISH: state_nxt = aether_pkg::IDLE;
      default:            state_nxt = aether_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= aether_pkg::IDLE;
      mac_en_q <= 1'b0;
    end else begin
      state_q  <= state_nxt;
      mac_en_q <= fetch;               // Lines up with read data
    end
  end

  assign mac_clr_o = (state_q == aether_pkg::IDLE) && start_i;
  assign mac_en_o  = mac_en_q;
  assign busy_o    = (state_q != aether_pkg::IDLE);
  assign done_o    = (state_q == aether_pkg::FINISH);

  // Host length must be a legal vector size at launch
  a_len_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> (length_i >= 1 && length_i <= `AE_BUF_DEPTH))
    else $error("dense run started with bad length");

endmodule

// File: verilog/aether_decoder.sv
`timescale 1ns/10ps
`include "aether_params.svh"

// Command front end
// Decodes one instruction per clock, holds the registers, drives buffer loads
module aether_decoder (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [3:0]        instruction_i,
  input  logic [3:0]        param_1_i,     // Register address
  input  aether_pkg::word_t param_2_i,     // Write or load data
  output aether_pkg::word_t data_o,
  output logic              interrupt_o,
  aether_buf_if.loader      buf_o,
  output logic              run_start_o,
  output aether_pkg::len_t  length_o,
  input  logic              busy_i,
  input  logic              done_i,
  input  aether_pkg::word_t result_i
);

  aether_pkg::instr_e    instr;
  aether_pkg::reg_addr_e reg_addr;

  logic run_busy;                        // Includes the pending start cycle
  logic load_start;
  logic load_cont;
  logic write_len;
  logic run_go;

  aether_pkg::len_t  length_q;
  aether_pkg::word_t result_q;
  aether_pkg::word_t rd_word;
  logic              done_q;

  aether_pkg::addr_t ld_count;
  logic              ld_at_end;

  assign instr    = aether_pkg::instr_e'(instruction_i);
  assign reg_addr = aether_pkg::reg_addr_e'(param_1_i);
  assign run_busy = busy_i | run_start_o;

  // --------------------
  // Command decode
  // --------------------
  // Loads, length writes and runs dropped while a run is live
  assign load_start = (instr == aether_pkg::LOAD_START) && !run_busy;
  assign load_cont  = (instr == aether_pkg::LOAD_CONT) && !run_busy;
  assign run_go     = (instr == aether_pkg::RUN_DENSE) && !run_busy;
  assign write_len  = (instr == aether_pkg::WRITE_REG) && (reg_addr == aether_pkg::LENGTH)
                      && !run_busy;

  // Load pointer holds the last written address
  aether_addr_counter u_ld_ptr (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clr_i    (load_start),
    .en_i     (load_cont),
    .last_i   (aether_pkg::addr_t'(`AE_BUF_DEPTH - 1)),
    .count_o  (ld_count),
    .at_end_o (ld_at_end)
  );

  // Write goes in at the sampling edge
  assign buf_o.wr_en   = load_start | load_cont;
  assign buf_o.wr_data = param_2_i;
  always_comb begin
    if (load_start) begin
      buf_o.wr_addr = '0;
    end else if (ld_at_end) begin
      buf_o.wr_addr = ld_count;             // Top word gets overwritten
    end else begin
      buf_o.wr_addr = ld_count + 1'b1;
    end
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      length_q    <= `AE_LEN_RESET;
      result_q    <= '0;
      done_q      <= 1'b0;
      run_start_o <= 1'b0;
    end else begin
      run_start_o <= run_go;                // Start pulse, one cycle
      if (write_len) length_q <= param_2_i[`AE_LEN_W-1:0];
      if (done_i) result_q <= result_i;     // Capture final sum
      if (done_i) begin
        done_q <= 1'b1;
      end else if (run_go || instr == aether_pkg::CLEAR) begin
        done_q <= 1'b0;
      end
    end
  end

  // Readback mux, unmapped reads as zero
  always_comb begin
    case (reg_addr)
      aether_pkg::VERSN:  rd_word = `AE_VERSION;
      aether_pkg::HWRID:  rd_word = `AE_HW_ID;
      aether_pkg::LENGTH: rd_word = aether_pkg::word_t'(length_q);
      aether_pkg::STATS:  rd_word = {14'd0, run_busy, done_q};   // Bit 1 running, bit 0 done
      aether_pkg::RESULT: rd_word = result_q;
      default:            rd_word = '0;
    endcase
  end

  // Holds until the next READ_REG
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_o <= '0;
    end else if (instr == aether_pkg::READ_REG) begin
      data_o <= rd_word;
    end
  end

  assign interrupt_o = done_q;
  assign length_o    = length_q;

  // Start only lands on an idle sequencer
  a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    run_start_o |-> !busy_i)
    else $error("run start while dense engine busy");

endmodule

// File: verilog/aether_engine.sv
`timescale 1ns/10ps

// Accelerator top, command port plus one dense path
module aether_engine (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [3:0]        instruction_i,
  input  logic [3:0]        param_1_i,
  input  aether_pkg::word_t param_2_i,
  output aether_pkg::word_t data_o,
  output logic              interrupt_o
);

  // --------------------
  // Internal wiring
  // --------------------
  aether_buf_if buf_if ();

  logic              run_start;
  aether_pkg::len_t  length;
  logic              busy;
  logic              done;
  logic              mac_clr;
  logic              mac_en;
  aether_pkg::word_t result;

  // Command front end
  aether_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instruction_i (instruction_i),
    .param_1_i     (param_1_i),
    .param_2_i     (param_2_i),
    .data_o        (data_o),
    .interrupt_o   (interrupt_o),
    .buf_o         (buf_if.loader),
    .run_start_o   (run_start),
    .length_o      (length),
    .busy_i        (busy),
    .done_i        (done),
    .result_i      (result)
  );

  aether_input_buffer u_buffer (
    .clk_i (clk_i),
    .buf_i (buf_if.mem)
  );

  // Dense path
  aether_dense_ctrl u_dense_ctrl (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (run_start),
    .length_i  (length),
    .buf_o     (buf_if.sequencer),
    .mac_clr_o (mac_clr),
    .mac_en_o  (mac_en),
    .busy_o    (busy),
    .done_o    (done)
  );

  aether_mac u_mac (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clr_i    (mac_clr),
    .en_i     (mac_en),
    .buf_i    (buf_if.mac),
    .result_o (result)
  );

endmodule

// File: test/tb_aether_engine.sv
`timescale 1ns/10ps

// Directed testbench for the dense dot-product engine
module tb_aether_engine;

  // Worst case per run plus loads, reads and reset
  localparam int run_cycles      = 256 + 3;
  localparam int watchdog_cycles = 8 * run_cycles + 600 + 200;

  logic        clk;
  logic        rst;
  logic [3:0]  instr;
  logic [3:0]  param_1;
  logic [15:0] param_2;
  logic [15:0] data;
  logic        irq;

  logic [15:0] model_mem [256];   // Mirror of the loaded buffer
  int          model_ptr;         // Mirror of the load pointer

  aether_engine dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .instruction_i (instr),
    .param_1_i     (param_1),
    .param_2_i     (param_2),
    .data_o        (data),
    .interrupt_o   (irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;        // 8 ns period
  end

  // Hang guard
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, a test hung", watchdog_cycles);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // Drive on the falling edge, sampled on the next rising edge
  task automatic send_cmd(input logic [3:0] op, input logic [3:0] p1, input logic [15:0] p2);
    instr   = op;
    param_1 = p1;
    param_2 = p2;
    @(negedge clk);
    instr = aether_pkg::NOP;      // Back to idle
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [15:0] exp, input string what);
    send_cmd(aether_pkg::READ_REG, addr, 16'h0000);
    check_word(data, exp, what);  // Registered one cycle after the read
  endtask

  task automatic load_word(input logic first, input logic [15:0] w);
    if (first) begin
      model_ptr = 0;
      send_cmd(aether_pkg::LOAD_START, 4'd0, w);
    end else begin
      if (model_ptr < 255) model_ptr++;   // Pointer sticks at the top word
      send_cmd(aether_pkg::LOAD_CONT, 4'd0, w);
    end
    model_mem[model_ptr] = w;
  endtask

  task automatic load_random(input int n);
    for (int i = 0; i < n; i++) begin
      load_word(i == 0, 16'($urandom));
    end
  endtask

  // Reference: sum of low byte times high byte, clamped to 16 bits signed
  function automatic logic [15:0] model_dot(input int len);
    int               sum;
    logic signed [7:0] lo;
    logic signed [7:0] hi;
    sum = 0;
    for (int i = 0; i < len; i++) begin
      lo  = model_mem[i][7:0];
      hi  = model_mem[i][15:8];
      sum += int'(lo) * int'(hi);
    end
    if (sum > 32767) return 16'h7FFF;
    if (sum < -32768) return 16'h8000;
    return 16'(sum);
  endfunction

  // Counts rising edges until the interrupt shows up
  task automatic wait_irq(input int limit, output int cycles);
    cycles = 0;
    while (!irq && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!irq) begin
      $display("Interrupt never rose within %0d cycles of the run start", limit);
      $display("TEST FAILED");
      $fatal(1, "no interrupt");
    end
  endtask

  task automatic run_and_check(input int len);
    int cycles;
    send_cmd(aether_pkg::WRITE_REG, aether_pkg::LENGTH, 16'(len));
    send_cmd(aether_pkg::RUN_DENSE, 4'd0, 16'h0000);
    wait_irq(run_cycles + 20, cycles);
    check_word(16'(cycles), 16'(len + 3), "interrupt latency");
    read_check(aether_pkg::STATS, 16'h0001, "status after run");
    read_check(aether_pkg::RESULT, model_dot(len), "dense result");
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_reset_identity();
    check_word(data, 16'h0000, "data after reset");
    check_word({15'd0, irq}, 16'h0000, "interrupt after reset");
    read_check(aether_pkg::VERSN, 16'h6C00, "version");
    read_check(aether_pkg::HWRID, 16'hB2E9, "hardware id");
    read_check(aether_pkg::LENGTH, 16'd4, "length reset");
    read_check(aether_pkg::STATS, 16'h0000, "status reset");
    read_check(aether_pkg::RESULT, 16'h0000, "result reset");
  endtask

  task automatic test_reg_write();
    int len;
    for (int i = 0; i < 8; i++) begin
      if (i == 0) len = 1;
      else if (i == 1) len = 256;          // Both ends of the range
      else len = $urandom_range(1, 256);
      send_cmd(aether_pkg::WRITE_REG, aether_pkg::LENGTH, 16'(len));
      read_check(aether_pkg::LENGTH, 16'(len), "length readback");
    end
    read_check(4'd9, 16'h0000, "unmapped register");
  endtask

  task automatic test_load_run();
    int len;
    repeat (3) begin
      len = $urandom_range(1, 64);
      load_random(len + $urandom_range(0, 4));  // Extra words must be ignored
      run_and_check(len);
    end
  endtask

  task automatic test_saturation();
    for (int i = 0; i < 4; i++) load_word(i == 0, 16'h7F7F);   // 127 x 127
    run_and_check(4);
    read_check(aether_pkg::RESULT, 16'h7FFF, "positive clamp");
    for (int i = 0; i < 4; i++) load_word(i == 0, 16'h7F80);   // -128 x 127
    run_and_check(4);
    read_check(aether_pkg::RESULT, 16'h8000, "negative clamp");
  endtask

  task automatic test_busy_rules();
    int          len;
    int          cycles;
    logic [15:0] expected;
    len = 48;
    load_random(len);
    expected = model_dot(len);
    send_cmd(aether_pkg::WRITE_REG, aether_pkg::LENGTH, 16'(len));
    send_cmd(aether_pkg::RUN_DENSE, 4'd0, 16'h0000);
    // Six one-cycle commands while the run is live, all but reads dropped
    send_cmd(aether_pkg::RUN_DENSE, 4'd0, 16'h0000);
    send_cmd(aether_pkg::LOAD_START, 4'd0, 16'h7F7F);
    send_cmd(aether_pkg::LOAD_CONT, 4'd0, 16'hFFFF);
    send_cmd(aether_pkg::WRITE_REG, aether_pkg::LENGTH, 16'd3);
    read_check(aether_pkg::STATS, 16'h0002, "running flag");
    read_check(aether_pkg::LENGTH, 16'(len), "length held during run");
    wait_irq(run_cycles + 20, cycles);
    check_word(16'(cycles + 6), 16'(len + 3), "busy run latency");
    read_check(aether_pkg::STATS, 16'h0001, "status after busy run");
    read_check(aether_pkg::RESULT, expected, "result with dropped commands");
    send_cmd(aether_pkg::CLEAR, 4'd0, 16'h0000);
    check_word({15'd0, irq}, 16'h0000, "interrupt after clear");
    read_check(aether_pkg::STATS, 16'h0000, "status after clear");
    // Rerun on the same words, words 0 and 1 still hold the original data
    run_and_check(len);
  endtask

  task automatic test_buffer_end();
    load_random(260);             // Last five land on word 255
    run_and_check(256);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(866));
    instr     = 4'd0;
    param_1   = 4'd0;
    param_2   = 16'h0000;
    rst       = 1'b1;
    model_ptr = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_identity();
    test_reg_write();
    test_load_run();
    test_saturation();
    test_busy_rules();
    test_buffer_end();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: build.f
+incdir+verilog
verilog/aether_pkg.sv
verilog/aether_buf_if.sv
verilog/aether_addr_counter.sv
verilog/aether_input_buffer.sv
verilog/aether_mac.sv
verilog/aether_dense_ctrl.sv
verilog/aether_decoder.sv
verilog/aether_engine.sv
test/tb_aether_engine.sv

// File: Makefile
# Verilator flow for the aether dense engine
VERILATOR  ?= verilator
TOP        ?= tb_aether_engine
RTL_TOP    ?= aether_engine
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= verilog/aether_pkg.sv verilog/aether_buf_if.sv \
              verilog/aether_addr_counter.sv verilog/aether_input_buffer.sv \
              verilog/aether_mac.sv verilog/aether_dense_ctrl.sv \
              verilog/aether_decoder.sv verilog/aether_engine.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+verilog $(RTL_SRCS) --top-module $(RTL_TOP)

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
